//--- files.f
+incdir+hw
hw/conv_pkg.sv
hw/pipe_reg.sv
hw/row_window_buffer.sv
hw/tap_config_regs.sv
hw/window_sequencer.sv
hw/mult_cube.sv
hw/conv_tap_top.sv
testbench/tb_conv_tap.sv

//--- hw/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

`define PIXEL_W 8
`define ROW_PIXELS 8
`define KDIM 3
`define PROD_W 16

// Weights sit at addresses 0 to 8
`define CFG_STRIDE_ADDR 9

`endif

//--- hw/conv_pkg.sv
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

	typedef logic [`PIXEL_W-1:0] pixel_t;

	// Pixel j at bits 8j+7:8j
	typedef pixel_t [`ROW_PIXELS-1:0] row_t;

	// Tap k at row k/3, column k%3
	typedef pixel_t [`KDIM*`KDIM-1:0] kernel_t;

	typedef logic [`PROD_W-1:0] prod_t;

	typedef struct packed {
		logic [2:0]                     col;   // Left pixel index
		pixel_t [`KDIM*`KDIM-1:0]       taps;
	} window_t;

	typedef struct packed {
		logic [2:0]                     col;
		prod_t [`KDIM*`KDIM-1:0]        prod;  // Unsummed tap products
	} result_t;

	typedef struct packed {
		logic [3:0]                     addr;
		pixel_t                         data;
	} cfg_wr_t;

endpackage

`default_nettype wire

//--- hw/conv_tap_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_tap_top
	import conv_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire          i_row_valid,
	input  wire row_t    i_row,
	output logic         o_row_ready,
	input  wire          i_cfg_wr,
	input  wire cfg_wr_t i_cfg,
	output logic         o_res_valid,
	output result_t      o_res,
	input  wire          i_res_ready
);

	row_t [`KDIM-1:0] rows;
	logic             full;
	logic             pop;
	logic             pop_two;
	logic             stride_two;
	kernel_t          kernel;

	logic             win_valid;
	logic             win_ready;
	window_t          win;
	logic             stg_valid;
	logic             stg_ready;
	window_t          stg_win;
	logic             cube_valid;
	logic             cube_ready;
	result_t          cube_res;

	row_window_buffer u_buffer (
		.clk(clk), .rst(rst),
		.i_row_valid(i_row_valid), .i_row(i_row), .o_row_ready(o_row_ready),
		.i_pop(pop), .i_pop_two(pop_two),
		.o_full(full), .o_rows(rows)
	);

	tap_config_regs u_cfg (
		.clk(clk), .rst(rst),
		.i_cfg_wr(i_cfg_wr), .i_cfg(i_cfg),
		.o_kernel(kernel), .o_stride_two(stride_two)
	);

	window_sequencer u_seq (
		.clk(clk), .rst(rst),
		.i_full(full), .i_rows(rows), .i_stride_two(stride_two),
		.o_pop(pop), .o_pop_two(pop_two),
		.o_win_valid(win_valid), .o_win(win), .i_win_ready(win_ready)
	);

	pipe_reg #(.payload_t(window_t)) u_win_stage (
		.clk(clk), .rst(rst),
		.i_valid(win_valid), .i_data(win), .o_ready(win_ready),
		.o_valid(stg_valid), .o_data(stg_win), .i_ready(stg_ready)
	);

	mult_cube u_cube (
		.clk(clk), .rst(rst),
		.i_valid(stg_valid), .i_win(stg_win), .o_ready(stg_ready),
		.i_kernel(kernel),
		.o_valid(cube_valid), .o_res(cube_res), .i_ready(cube_ready)
	);

	pipe_reg #(.payload_t(result_t)) u_res_stage (
		.clk(clk), .rst(rst),
		.i_valid(cube_valid), .i_data(cube_res), .o_ready(cube_ready),
		.o_valid(o_res_valid), .o_data(o_res), .i_ready(i_res_ready)
	);

endmodule

`default_nettype wire

//--- hw/mult_cube.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module mult_cube
	import conv_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire          i_valid,
	input  wire window_t i_win,
	output logic         o_ready,
	input  wire kernel_t i_kernel,
	output logic         o_valid,
	output result_t      o_res,
	input  wire          i_ready
);

	assign o_ready = !o_valid || i_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_valid <= 1'b0;
		end else if (o_ready) begin
			o_valid <= i_valid;
		end
	end

	// Nine 8x8 multipliers, column tag rides along
	always_ff @(posedge clk) begin
		if (o_ready && i_valid) begin
			o_res.col <= i_win.col;
			for (int k = 0; k < `KDIM * `KDIM; k++) begin
				o_res.prod[k] <= i_win.taps[k] * i_kernel[k];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg
	import conv_pkg::*;
#(
	parameter type payload_t = window_t
) (
	input  wire      clk,
	input  wire      rst,
	input  wire      i_valid,
	input  wire payload_t i_data,
	output logic     o_ready,
	output logic     o_valid,
	output payload_t o_data,
	input  wire      i_ready
);

	// Accept when empty or when the held entry leaves this cycle
	assign o_ready = !o_valid || i_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_valid <= 1'b0;
		end else if (o_ready) begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (o_ready && i_valid) begin
			o_data <= i_data;
		end
	end

	// A stalled entry stays put until the consumer takes it
	a_hold_stalled: assert property (
		@(posedge clk) disable iff (!rst)
		o_valid && !i_ready |=> o_valid && $stable(o_data)
	);

endmodule

`default_nettype wire

//--- hw/row_window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module row_window_buffer
	import conv_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             i_row_valid,
	input  wire row_t       i_row,
	output logic            o_row_ready,
	input  wire             i_pop,
	input  wire             i_pop_two,
	output logic            o_full,
	output row_t [`KDIM-1:0] o_rows
);

	logic [1:0] count_q;
	logic       row_take;

	assign o_row_ready = count_q < 2'(`KDIM);
	assign o_full      = count_q == 2'(`KDIM);
	assign row_take    = i_row_valid && o_row_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count_q <= 2'd0;
		end else if (i_pop) begin
			count_q <= count_q - (i_pop_two ? 2'd2 : 2'd1);
		end else if (row_take) begin
			count_q <= count_q + 2'd1;
		end
	end

	// Slot 0 holds the oldest row
	always_ff @(posedge clk) begin
		if (i_pop) begin
			if (i_pop_two) begin
				o_rows[0] <= o_rows[2];    // Only the newest row survives
			end else begin
				o_rows[0] <= o_rows[1];
				o_rows[1] <= o_rows[2];
			end
		end else if (row_take) begin
			o_rows[count_q] <= i_row;      // Youngest free slot
		end
	end

	// The sequencer may only retire rows out of a complete window set
	a_pop_when_full: assert property (
		@(posedge clk) disable iff (!rst)
		i_pop |-> o_full
	);

endmodule

`default_nettype wire

//--- hw/tap_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module tap_config_regs
	import conv_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire          i_cfg_wr,
	input  wire cfg_wr_t i_cfg,
	output kernel_t      o_kernel,
	output logic         o_stride_two
);

	logic is_stride;
	logic is_weight;

	assign is_stride = i_cfg.addr == 4'(`CFG_STRIDE_ADDR);
	assign is_weight = i_cfg.addr < 4'(`KDIM * `KDIM);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_kernel     <= '0;
			o_stride_two <= 1'b0;    // Stride 1
		end else if (i_cfg_wr) begin
			if (is_stride) begin
				o_stride_two <= i_cfg.data[0];    // Bit 0 set selects stride 2
			end else if (is_weight) begin
				o_kernel[i_cfg.addr] <= i_cfg.data;
			end
		end
	end

	// Addresses above the stride register are unmapped
	a_cfg_addr_range: assert property (
		@(posedge clk) disable iff (!rst)
		i_cfg_wr |-> i_cfg.addr <= 4'(`CFG_STRIDE_ADDR)
	);

endmodule

`default_nettype wire

//--- hw/window_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module window_sequencer
	import conv_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire              i_full,
	input  wire row_t [`KDIM-1:0] i_rows,
	input  wire              i_stride_two,
	output logic             o_pop,
	output logic             o_pop_two,
	output logic             o_win_valid,
	output window_t          o_win,
	input  wire              i_win_ready
);

	// Rightmost window that still fits inside a row
	localparam int LAST_COL = `ROW_PIXELS - `KDIM;

	logic [2:0] col_q;
	logic [3:0] next_col;
	logic       last_col;
	logic       win_fire;

	assign o_win_valid = i_full;
	assign win_fire    = o_win_valid && i_win_ready;

	assign next_col = {1'b0, col_q} + (i_stride_two ? 4'd2 : 4'd1);
	assign last_col = next_col > 4'(LAST_COL);

	// Row set retires after its last window is accepted
	assign o_pop     = win_fire && last_col;
	assign o_pop_two = o_pop && i_stride_two;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			col_q <= 3'd0;
		end else if (win_fire) begin
			if (last_col) begin
				col_q <= 3'd0;
			end else begin
				col_q <= next_col[2:0];
			end
		end
	end

	// Tap r*3+c comes from buffered row r, pixel col+c
	always_comb begin
		o_win.col = col_q;
		for (int r = 0; r < `KDIM; r++) begin
			for (int c = 0; c < `KDIM; c++) begin
				o_win.taps[r*`KDIM + c] = i_rows[r][col_q + c];
			end
		end
	end

	// Window must never run past the right edge of the row
	a_col_in_row: assert property (
		@(posedge clk) disable iff (!rst)
		col_q <= 3'(LAST_COL)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the conv tap testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_tap \
	-f files.f > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_conv_tap > sim.log 2>&1
grep -q "^Result: PASSED$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/tb_conv_tap.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module tb_conv_tap
	import conv_pkg::*;
();

	localparam int CLK_PERIOD     = 4;
	localparam int ROW_TIMEOUT    = 100;
	localparam int RESULT_TIMEOUT = 200;
	localparam int TEST_CYCLES    = 6 * 300;    // Six tests, generous budget each
	localparam int MARGIN         = 4;
	localparam int SEED           = 32'ha6eb;

	logic    clk;
	logic    rst;
	logic    i_row_valid;
	row_t    i_row;
	logic    o_row_ready;
	logic    i_cfg_wr;
	cfg_wr_t i_cfg;
	logic    o_res_valid;
	result_t o_res;
	logic    i_res_ready;

	kernel_t weights;
	logic    stride_two_m;
	row_t    model_rows[$];
	result_t expect_q[$];
	result_t exp_res;
	result_t prev_res;
	logic    prev_stall;
	int      errors;
	int      checks;
	int      got_count;

	conv_tap_top dut (
		.clk(clk), .rst(rst),
		.i_row_valid(i_row_valid), .i_row(i_row), .o_row_ready(o_row_ready),
		.i_cfg_wr(i_cfg_wr), .i_cfg(i_cfg),
		.o_res_valid(o_res_valid), .o_res(o_res), .i_res_ready(i_res_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TEST_CYCLES * MARGIN * CLK_PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	// Tap k = pixel (col + k%3) of model row k/3, times weight k
	function automatic result_t window_result(input int col);
		result_t r;
		r.col = 3'(col);
		for (int k = 0; k < `KDIM * `KDIM; k++) begin
			r.prod[k] = 16'(model_rows[k / `KDIM][col + k % `KDIM]) * 16'(weights[k]);
		end
		return r;
	endfunction

	function automatic row_t ramp_row(input int base);
		row_t r;
		for (int j = 0; j < `ROW_PIXELS; j++) begin
			r[j] = 8'(base + 3 * j);
		end
		return r;
	endfunction

	function automatic row_t random_row();
		row_t r;
		for (int j = 0; j < `ROW_PIXELS; j++) begin
			r[j] = 8'($urandom);
		end
		return r;
	endfunction

	task automatic take_row_model(input row_t row);
		model_rows.push_back(row);
		if (model_rows.size() == `KDIM) begin
			for (int c = 0; c <= `ROW_PIXELS - `KDIM; c += (stride_two_m ? 2 : 1)) begin
				expect_q.push_back(window_result(c));
			end
			model_rows.pop_front();
			if (stride_two_m) begin
				model_rows.pop_front();
			end
		end
	endtask

	task automatic send_row(input row_t row);
		int   waited;
		logic taken;
		logic ready_now;
		waited = 0;
		taken  = 1'b0;
		@(negedge clk);
		i_row_valid = 1'b1;
		i_row       = row;
		while (!taken && waited < ROW_TIMEOUT) begin
			ready_now = o_row_ready;    // Stable until the next rising edge
			@(posedge clk);
			if (ready_now) begin
				taken = 1'b1;
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		@(negedge clk);
		i_row_valid = 1'b0;
		checks++;
		assert (taken) else begin
			errors++;
			$display("Row was not accepted within %0d cycles", ROW_TIMEOUT);
		end
		if (taken) begin
			take_row_model(row);
		end
	endtask

	task automatic write_cfg(input logic [3:0] addr, input pixel_t data);
		@(negedge clk);
		i_cfg_wr   = 1'b1;
		i_cfg.addr = addr;
		i_cfg.data = data;
		@(negedge clk);
		i_cfg_wr = 1'b0;
	endtask

	task automatic load_config(input kernel_t kern, input logic s2);
		weights      = kern;
		stride_two_m = s2;
		for (int k = 0; k < `KDIM * `KDIM; k++) begin
			write_cfg(4'(k), kern[k]);
		end
		write_cfg(4'(`CFG_STRIDE_ADDR), {7'd0, s2});
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b1;
		model_rows.delete();
		expect_q.delete();
	endtask

	task automatic wait_results(input int start, input int count);
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < RESULT_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		repeat (8) @(negedge clk);    // Room for a stray extra result
		checks++;
		assert (expect_q.size() == 0) else begin
			errors++;
			$display("Timed out with %0d results still missing", expect_q.size());
		end
		checks++;
		assert (got_count - start == count) else begin
			errors++;
			$display("Expected %0d results but received %0d", count, got_count - start);
		end
	endtask

	// Handshake and stall checks on the result port
	always @(posedge clk) begin
		if (!rst) begin
			prev_stall = 1'b0;
		end else begin
			if (prev_stall) begin
				checks++;
				assert (o_res_valid && o_res == prev_res) else begin
					errors++;
					$display("Stalled result was dropped or changed before it was taken");
				end
			end
			if (o_res_valid && i_res_ready) begin
				got_count++;
				checks++;
				assert (expect_q.size() != 0) else begin
					errors++;
					$display("Unexpected extra result at column %0d", o_res.col);
				end
				if (expect_q.size() != 0) begin
					exp_res = expect_q.pop_front();
					assert (o_res.col == exp_res.col) else begin
						errors++;
						$display("** Error o_res.col: got %h, expected %h", o_res.col, exp_res.col);
					end
					for (int k = 0; k < `KDIM * `KDIM; k++) begin
						assert (o_res.prod[k] == exp_res.prod[k]) else begin
							errors++;
							$display("** Error o_res.prod[%0d]: got %h, expected %h",
								k, o_res.prod[k], exp_res.prod[k]);
						end
					end
				end
			end
			prev_stall = o_res_valid && !i_res_ready;
			prev_res   = o_res;
		end
	end

	task automatic reset_state_check();
		apply_reset();
		@(negedge clk);
		checks += 2;
		assert (o_res_valid == 1'b0) else begin
			errors++;
			$display("** Error o_res_valid: got %h, expected %h", o_res_valid, 1'b0);
		end
		assert (o_row_ready == 1'b1) else begin
			errors++;
			$display("** Error o_row_ready: got %h, expected %h", o_row_ready, 1'b1);
		end
	endtask

	task automatic stride_one_window();
		int start;
		apply_reset();
		load_config({8'd9, 8'd8, 8'd7, 8'd6, 8'd5, 8'd4, 8'd3, 8'd2, 8'd1}, 1'b0);
		start = got_count;
		send_row(ramp_row(8'h10));
		send_row(ramp_row(8'h40));
		send_row(ramp_row(8'h90));
		wait_results(start, 6);
	endtask

	task automatic stride_two_window();
		int start;
		apply_reset();
		load_config({8'd2, 8'd7, 8'd1, 8'd5, 8'd3, 8'd9, 8'd4, 8'd6, 8'd8}, 1'b1);
		start = got_count;
		for (int i = 0; i < 5; i++) begin
			send_row(ramp_row(8'h11 + 8'h25 * i));    // Rows 3 and 4 refill after a pop of two
		end
		wait_results(start, 6);
	endtask

	task automatic random_row_stream();
		int start;
		apply_reset();
		load_config(kernel_t'({$urandom, $urandom, $urandom}), 1'b0);
		start = got_count;
		for (int i = 0; i < 5; i++) begin
			send_row(random_row());
		end
		wait_results(start, 18);
	endtask

	task automatic random_back_pressure();
		int   start;
		logic stop;
		apply_reset();
		load_config(kernel_t'({$urandom, $urandom, $urandom}), 1'b0);
		start = got_count;
		stop  = 1'b0;
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					send_row(random_row());
				end
				wait_results(start, 24);
				stop = 1'b1;
			end
			begin
				while (!stop) begin
					@(negedge clk);
					i_res_ready = 1'($urandom_range(0, 1));
				end
			end
		join
		@(negedge clk);
		i_res_ready = 1'b1;
	endtask

	task automatic full_scale_products();
		int start;
		int seen;
		int waited;
		apply_reset();
		load_config({9{8'hff}}, 1'b0);
		start  = got_count;
		seen   = 0;
		waited = 0;
		for (int i = 0; i < 3; i++) begin
			send_row({8{8'hff}});
		end
		// 255 * 255 fills all sixteen product bits
		while (seen < 6 && waited < RESULT_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (o_res_valid && i_res_ready) begin
				seen++;
				for (int k = 0; k < `KDIM * `KDIM; k++) begin
					checks++;
					assert (o_res.prod[k] == 16'hfe01) else begin
						errors++;
						$display("** Error o_res.prod[%0d]: got %h, expected %h",
							k, o_res.prod[k], 16'hfe01);
					end
				end
			end
		end
		wait_results(start, 6);
	endtask

	initial begin
		rst          = 1'b0;
		i_row_valid  = 1'b0;
		i_row        = '0;
		i_cfg_wr     = 1'b0;
		i_cfg        = '0;
		i_res_ready  = 1'b1;
		weights      = '0;
		stride_two_m = 1'b0;
		prev_stall   = 1'b0;
		prev_res     = '0;
		errors       = 0;
		checks       = 0;
		got_count    = 0;
		void'($urandom(SEED));
		reset_state_check();
		stride_one_window();
		stride_two_window();
		random_row_stream();
		random_back_pressure();
		full_scale_products();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
